/* design/uart_cfg_pkg.sv */
package uart_cfg_pkg;

    // ------------------------------
    // baud timing
    // ------------------------------

    // cycles left in the current bit period
    // 16 bits caps clks_per_bit at 65535
    typedef logic [15:0] baud_cnt_t;

    // ------------------------------
    // frame indexing
    // ------------------------------

    // data bit position, lsb first
    typedef logic [2:0] bit_idx_t;

endpackage

/* design/uart_frame_pkg.sv */
package uart_frame_pkg;

    // ------------------------------
    // payload
    // ------------------------------

    typedef logic [7:0] data_byte_t;   // one 8N1 data byte

    // ------------------------------
    // serial FSMs
    // ------------------------------

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,               // waiting for falling edge
        rx_start = 2'd1,               // half bit, start re-check
        rx_data  = 2'd2,               // 8 data samples
        rx_stop  = 2'd3                // stop bit sample
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle  = 2'd0,               // line high, ready
        tx_start = 2'd1,               // driving start bit
        tx_data  = 2'd2,               // driving data bits
        tx_stop  = 2'd3                // driving stop bit
    } tx_state_t;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter uart_cfg_pkg::baud_cnt_t clks_per_bit = 16'd10416
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       rxd,
    output uart_frame_pkg::data_byte_t rx_byte,
    output logic                       rx_valid,
    output logic                       rx_frame_err
);

    localparam uart_cfg_pkg::baud_cnt_t bit_last  = clks_per_bit - 16'd1;
    localparam uart_cfg_pkg::baud_cnt_t half_last = (clks_per_bit >> 1) - 16'd1;

    logic rxd_meta;                    // first sync stage
    logic rxd_sync;                    // usable line value
    logic rxd_prev;                    // for edge detect
    logic fall_edge;
    logic sample_now;                  // counter expired
    logic stop_sample;

    uart_frame_pkg::rx_state_t state;
    uart_cfg_pkg::baud_cnt_t   baud_cnt;
    uart_cfg_pkg::bit_idx_t    bit_idx;

    // ------------------------------
    // input synchronizer
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta <= 1'b1;          // idle line is high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall_edge  = rxd_prev & ~rxd_sync;
    assign sample_now = (baud_cnt == '0);

    // ------------------------------
    // frame FSM
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= uart_frame_pkg::rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state != uart_frame_pkg::rx_idle && !sample_now) begin
                baud_cnt <= baud_cnt - 16'd1;
            end
            case (state)
                uart_frame_pkg::rx_idle: begin
                    bit_idx <= '0;
                    if (fall_edge) begin
                        baud_cnt <= half_last;    // aim at middle of start bit
                        state    <= uart_frame_pkg::rx_start;
                    end
                end
                uart_frame_pkg::rx_start: begin
                    if (sample_now) begin
                        if (rxd_sync) begin
                            state <= uart_frame_pkg::rx_idle;   // glitch, drop it
                        end else begin
                            baud_cnt <= bit_last;
                            state    <= uart_frame_pkg::rx_data;
                        end
                    end
                end
                uart_frame_pkg::rx_data: begin
                    if (sample_now) begin
                        baud_cnt <= bit_last;
                        bit_idx  <= bit_idx + 3'd1;             // wraps after bit 7
                        if (bit_idx == 3'd7) begin
                            state <= uart_frame_pkg::rx_stop;
                        end
                    end
                end
                uart_frame_pkg::rx_stop: begin
                    if (sample_now) begin
                        state <= uart_frame_pkg::rx_idle;       // rearm mid stop bit
                    end
                end
                default: state <= uart_frame_pkg::rx_idle;
            endcase
        end
    end

    // data bits land lsb first
    always_ff @(posedge clk) begin
        if (state == uart_frame_pkg::rx_data && sample_now) begin
            rx_byte[bit_idx] <= rxd_sync;
        end
    end

    // ------------------------------
    // stop bit result
    // ------------------------------

    assign stop_sample  = (state == uart_frame_pkg::rx_stop) && sample_now;
    assign rx_valid     = stop_sample & rxd_sync;     // good frame
    assign rx_frame_err = stop_sample & ~rxd_sync;    // stop read low

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
    parameter uart_cfg_pkg::baud_cnt_t clks_per_bit = 16'd10416
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       tx_start,
    input  uart_frame_pkg::data_byte_t tx_byte,
    input  logic                       cts,
    output logic                       txd,
    output logic                       tx_busy
);

    localparam uart_cfg_pkg::baud_cnt_t bit_last = clks_per_bit - 16'd1;

    uart_frame_pkg::tx_state_t  state;
    uart_cfg_pkg::baud_cnt_t    baud_cnt;
    uart_cfg_pkg::bit_idx_t     bit_idx;
    uart_cfg_pkg::bit_idx_t     next_idx;
    uart_frame_pkg::data_byte_t tx_data;    // byte being shifted out

    logic bit_done;
    logic start_ok;

    assign bit_done = (baud_cnt == '0);
    assign next_idx = bit_idx + 3'd1;
    assign start_ok = (state == uart_frame_pkg::tx_idle) && tx_start && cts;  // cts gates only here
    assign tx_busy  = (state != uart_frame_pkg::tx_idle);

    // ------------------------------
    // frame FSM
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= uart_frame_pkg::tx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;
        end else begin
            if (state != uart_frame_pkg::tx_idle && !bit_done) begin
                baud_cnt <= baud_cnt - 16'd1;
            end
            case (state)
                uart_frame_pkg::tx_idle: begin
                    if (start_ok) begin
                        txd      <= 1'b0;                  // start bit
                        baud_cnt <= bit_last;
                        state    <= uart_frame_pkg::tx_start;
                    end
                end
                uart_frame_pkg::tx_start: begin
                    if (bit_done) begin
                        txd      <= tx_data[0];
                        bit_idx  <= '0;
                        baud_cnt <= bit_last;
                        state    <= uart_frame_pkg::tx_data;
                    end
                end
                uart_frame_pkg::tx_data: begin
                    if (bit_done) begin
                        baud_cnt <= bit_last;
                        bit_idx  <= next_idx;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;                 // stop bit
                            state <= uart_frame_pkg::tx_stop;
                        end else begin
                            txd <= tx_data[next_idx];
                        end
                    end
                end
                uart_frame_pkg::tx_stop: begin
                    if (bit_done) begin
                        state <= uart_frame_pkg::tx_idle;  // txd already high
                    end
                end
                default: state <= uart_frame_pkg::tx_idle;
            endcase
        end
    end

    // capture payload on accept
    always_ff @(posedge clk) begin
        if (start_ok) begin
            tx_data <= tx_byte;
        end
    end

endmodule

/* design/uart_link_ctrl.sv */
`timescale 1ns/10ps

module uart_link_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  uart_frame_pkg::data_byte_t rx_byte,
    input  logic                       rx_valid,
    input  logic                       rx_frame_err,
    input  logic                       tx_busy,
    input  logic                       err_clr,
    output uart_frame_pkg::data_byte_t tx_byte,
    output logic                       tx_start,
    output uart_frame_pkg::data_byte_t leds,
    output logic                       overrun,
    output logic                       frame_err
);

    logic hold_full;       // echo register occupied
    logic tx_busy_d;
    logic tx_busy_rise;    // transmitter took the byte
    logic hold_free;

    assign tx_busy_rise = tx_busy & ~tx_busy_d;
    assign hold_free    = ~hold_full | tx_busy_rise;

    // ------------------------------
    // echo holding register
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy_d <= 1'b0;
            hold_full <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            tx_busy_d <= tx_busy;
            if (rx_valid && hold_free) begin
                hold_full <= 1'b1;
            end else if (tx_busy_rise) begin
                hold_full <= 1'b0;
            end
            // one cycle strobe, retried every other cycle while held off
            tx_start <= hold_full & ~tx_busy & ~tx_start;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && hold_free) begin
            tx_byte <= rx_byte;
        end
    end

    // ------------------------------
    // leds and sticky flags
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            leds      <= '0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (rx_valid) begin
                leds <= rx_byte;                 // last good byte, even if dropped
            end
            if (rx_valid && !hold_free) begin
                overrun <= 1'b1;                 // set beats clear
            end else if (err_clr) begin
                overrun <= 1'b0;
            end
            if (rx_frame_err) begin
                frame_err <= 1'b1;
            end else if (err_clr) begin
                frame_err <= 1'b0;
            end
        end
    end

endmodule

/* design/uart_echo_top.sv */
`timescale 1ns/10ps

module uart_echo_top #(
    parameter uart_cfg_pkg::baud_cnt_t clks_per_bit = 16'd10416
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       rxd,
    input  logic                       cts,
    input  logic                       err_clr,
    output logic                       txd,
    output uart_frame_pkg::data_byte_t leds,
    output logic                       overrun,
    output logic                       frame_err
);

    // ------------------------------
    // rx to controller
    // ------------------------------
    uart_frame_pkg::data_byte_t rx_byte;
    logic                       rx_valid;
    logic                       rx_frame_err;

    // ------------------------------
    // controller and tx
    // ------------------------------
    uart_frame_pkg::data_byte_t tx_byte;
    logic                       tx_start;
    logic                       tx_busy;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_rx (
        .clk          (clk),
        .arst_n       (arst_n),
        .rxd          (rxd),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    uart_link_ctrl u_link_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .tx_busy      (tx_busy),
        .err_clr      (err_clr),
        .tx_byte      (tx_byte),
        .tx_start     (tx_start),
        .leds         (leds),
        .overrun      (overrun),
        .frame_err    (frame_err)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_tx (
        .clk          (clk),
        .arst_n       (arst_n),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .cts          (cts),
        .txd          (txd),
        .tx_busy      (tx_busy)
    );

endmodule

/* testbench/uart_echo_properties.sv */
`timescale 1ns/10ps

module uart_echo_properties (
    input logic clk,
    input logic arst_n,
    input logic rx_valid,
    input logic rx_frame_err,
    input logic tx_start,
    input logic tx_busy,
    input logic txd
);

    // a stop bit is either good or bad, never both
    rx_result_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(rx_valid && rx_frame_err))
        else $error("rx_valid and rx_frame_err high in the same cycle");

    tx_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start issued while the transmitter was busy");

    txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
        !tx_busy |-> txd)
        else $error("txd low while the transmitter was idle");

endmodule

bind uart_echo_top uart_echo_properties u_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err),
    .tx_start     (tx_start),
    .tx_busy      (tx_busy),
    .txd          (txd)
);

/* testbench/uart_echo_tb.sv */
`timescale 1ns/10ps

module uart_echo_tb;

    localparam int bit_cycles = 16;
    localparam int echo_wait  = 40 * bit_cycles;   // generous start-edge timeout

    logic                       clk;
    logic                       arst_n;
    logic                       rxd;
    logic                       cts;
    logic                       err_clr;
    logic                       txd;
    uart_frame_pkg::data_byte_t leds;
    logic                       overrun;
    logic                       frame_err;

    uart_frame_pkg::data_byte_t stream_bytes [8];
    uart_frame_pkg::data_byte_t got;
    uart_frame_pkg::data_byte_t byte_a;
    uart_frame_pkg::data_byte_t byte_b;
    uart_frame_pkg::data_byte_t leds_before;
    logic                       ov_before;
    logic                       fe_before;

    uart_echo_top #(
        .clks_per_bit (16'd16)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .rxd       (rxd),
        .cts       (cts),
        .err_clr   (err_clr),
        .txd       (txd),
        .leds      (leds),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

    always #2 clk = ~clk;

    // ------------------------------
    // checks and helpers
    // ------------------------------

    task automatic compare_byte(input string name, input uart_frame_pkg::data_byte_t expected,
                                input uart_frame_pkg::data_byte_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while %s.", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    function automatic uart_frame_pkg::data_byte_t rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic sync_drive();
        @(posedge clk);
        #1;                                          // inputs move 1 ns after the edge
    endtask

    // expects to start 1 ns after a rising edge, leaves the line idle
    task automatic send_frame(input uart_frame_pkg::data_byte_t data, input logic stop_level);
        rxd = 1'b0;
        repeat (bit_cycles) @(posedge clk);
        #1;
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];                           // lsb first
            repeat (bit_cycles) @(posedge clk);
            #1;
        end
        rxd = stop_level;
        repeat (bit_cycles) @(posedge clk);
        #1;
        rxd = 1'b1;
    endtask

    // returns in the middle of the stop bit
    task automatic recv_frame(input string name, input int timeout_cycles,
                              output uart_frame_pkg::data_byte_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (txd !== 1'b0) begin
            if (waited >= timeout_cycles) begin
                report_timeout({"waiting for an echo start bit in ", name});
            end
            waited++;
            @(negedge clk);
        end
        repeat (bit_cycles / 2 - 1) @(negedge clk);  // mid start bit
        compare_flag({name, " start bit"}, 1'b0, txd);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(negedge clk);
            data[i] = txd;
        end
        repeat (bit_cycles) @(negedge clk);
        compare_flag({name, " stop bit"}, 1'b1, txd);
    endtask

    task automatic expect_idle(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_flag({name, " txd idle"}, 1'b1, txd);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic test_single();
        byte_a = rand_byte();
        fork
            send_frame(byte_a, 1'b1);
            recv_frame("test_single", echo_wait, got);
        join
        compare_byte("test_single echo", byte_a, got);
        sync_drive();
        compare_byte("test_single leds", byte_a, leds);
        compare_flag("test_single overrun", 1'b0, overrun);
        compare_flag("test_single frame_err", 1'b0, frame_err);
    endtask

    task automatic test_stream();
        foreach (stream_bytes[i]) stream_bytes[i] = rand_byte();
        fork
            for (int i = 0; i < 8; i++) send_frame(stream_bytes[i], 1'b1);
            for (int i = 0; i < 8; i++) begin
                recv_frame("test_stream", echo_wait, got);
                compare_byte($sformatf("test_stream echo %0d", i), stream_bytes[i], got);
            end
        join
        sync_drive();
        compare_flag("test_stream overrun", 1'b0, overrun);
    endtask

    task automatic test_overrun();
        byte_a = rand_byte();
        byte_b = rand_byte();
        if (byte_b == byte_a) byte_b = ~byte_a;
        cts = 1'b0;                                  // hold the transmitter off
        send_frame(byte_a, 1'b1);
        send_frame(byte_b, 1'b1);
        compare_flag("test_overrun overrun", 1'b1, overrun);
        compare_byte("test_overrun leds", byte_b, leds);
        expect_idle("test_overrun blocked", bit_cycles);
        sync_drive();
        cts = 1'b1;
        recv_frame("test_overrun", echo_wait, got);
        compare_byte("test_overrun echo", byte_a, got);
        expect_idle("test_overrun second frame", 12 * bit_cycles);
        sync_drive();
    endtask

    task automatic test_frame_err();
        leds_before = leds;
        byte_a      = rand_byte();
        if (byte_a == leds_before) byte_a = ~byte_a;
        send_frame(byte_a, 1'b0);                    // stop bit low
        compare_flag("test_frame_err frame_err", 1'b1, frame_err);
        compare_byte("test_frame_err leds", leds_before, leds);
        expect_idle("test_frame_err no echo", 12 * bit_cycles);
        sync_drive();
    endtask

    task automatic test_clear();
        compare_flag("test_clear overrun set", 1'b1, overrun);
        compare_flag("test_clear frame_err set", 1'b1, frame_err);
        err_clr = 1'b1;
        sync_drive();
        err_clr = 1'b0;
        compare_flag("test_clear overrun", 1'b0, overrun);
        compare_flag("test_clear frame_err", 1'b0, frame_err);
    endtask

    task automatic test_glitch();
        leds_before = leds;
        ov_before   = overrun;
        fe_before   = frame_err;
        rxd = 1'b0;                                  // a quarter bit, well short of mid-bit
        repeat (4) @(posedge clk);
        #1;
        rxd = 1'b1;
        expect_idle("test_glitch no echo", 12 * bit_cycles);  // longer than a false frame
        sync_drive();
        compare_byte("test_glitch leds", leds_before, leds);
        compare_flag("test_glitch overrun", ov_before, overrun);
        compare_flag("test_glitch frame_err", fe_before, frame_err);
        byte_a = rand_byte();
        fork
            send_frame(byte_a, 1'b1);
            recv_frame("test_glitch", echo_wait, got);
        join
        compare_byte("test_glitch echo", byte_a, got);
        sync_drive();
        compare_byte("test_glitch leds after", byte_a, leds);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        void'($urandom(32'habe20fdb));
        clk     = 1'b0;
        arst_n  = 1'b0;
        rxd     = 1'b1;                              // idle line
        cts     = 1'b1;
        err_clr = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        sync_drive();
        compare_flag("reset txd", 1'b1, txd);
        compare_byte("reset leds", 8'h00, leds);
        compare_flag("reset overrun", 1'b0, overrun);
        compare_flag("reset frame_err", 1'b0, frame_err);
        test_single();
        test_stream();
        test_overrun();
        test_frame_err();
        test_clear();
        test_glitch();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* build.f */
design/uart_cfg_pkg.sv
design/uart_frame_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_link_ctrl.sv
design/uart_echo_top.sv
testbench/uart_echo_properties.sv
testbench/uart_echo_tb.sv

/* Bender.yml */
package:
  name: uart_echo

sources:
  # packages first, then the design bottom up
  - design/uart_cfg_pkg.sv
  - design/uart_frame_pkg.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/uart_link_ctrl.sv
  - design/uart_echo_top.sv

  - target: simulation
    files:
      - testbench/uart_echo_properties.sv
      - testbench/uart_echo_tb.sv
